/* flist.f */
rtl/counterPkg.sv
rtl/PrefixAnd.sv
rtl/IncDec.sv
rtl/cmdDispatch.sv
rtl/channelCounter.sv
rtl/readoutMux.sv
rtl/counterBank.sv
verif/clkGen.sv
verif/counterBankTb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the counter bank regression with Verilator

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --assert --timescale 1ns/100ps \
	--top-module counterBankTb -Mdir obj_dir -f flist.f
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/VcounterBankTb > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

# the testbench prints the pass line only when every check held
if grep -q "^Regression passed$" "$logFile"; then
	exit 0
fi
exit 1

/* verif/counterBankTb.sv */
module counterBankTb
	import counterPkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	// cycle budget per test
	localparam int budReset    = 30;
	localparam int budRandom   = 440;
	localparam int budUpWrap   = 20;
	localparam int budDownWrap = 30;
	localparam int budClear    = 20;
	localparam int budTiming   = 30;
	// run stops at twice the summed budget plus 100
	localparam int cycleLimit  =
		2 * (budReset + budRandom + budUpWrap + budDownWrap + budClear + budTiming) + 100;
	localparam int respTimeout = 8;  // cycles to wait for outstanding responses

	logic  clk;
	logic  arstN;
	logic  cmdValid;
	chanT  cmdChan;
	opT    cmdOp;
	countT cmdData;
	logic  rdValid;
	chanT  rdChan;
	logic  rdRespValid;
	countT rdCount;
	logic  rdWrap;

	// reference model state
	countT    modelCount [numChannels];
	logic     modelWrap  [numChannels];
	logic     pendValid;     // command sitting in the dispatcher
	chanT     pendChan;
	opT       pendOp;
	countT    pendData;
	chanMaskT clrPend;       // flag clears from last cycle's read
	logic     expRespValid;  // expected response for the current cycle
	countT    expCount;
	logic     expWrap;

	int checkFails  = 0;
	int startFails  = 0;
	int testsPassed = 0;
	int testsFailed = 0;
	int readsIssued = 0;
	int respSeen    = 0;
	int cycleCount  = 0;

	clkGen u_clkGen (
		.clk  (clk),
		.arstN(arstN)
	);

	counterBank u_counterBank (
		.clk        (clk),
		.arstN      (arstN),
		.cmdValid   (cmdValid),
		.cmdChan    (cmdChan),
		.cmdOp      (cmdOp),
		.cmdData    (cmdData),
		.rdValid    (rdValid),
		.rdChan     (rdChan),
		.rdRespValid(rdRespValid),
		.rdCount    (rdCount),
		.rdWrap     (rdWrap)
	);

	// reference model stepped at each rising edge like the two-edge command path
	always @(posedge clk or negedge arstN) begin : refModel
		chanMaskT newClr;
		logic     hit;
		if (!arstN) begin
			for (int ch = 0; ch < numChannels; ch++) begin
				modelCount[ch] = '0;
				modelWrap[ch]  = 1'b0;
			end
			pendValid    = 1'b0;
			pendChan     = '0;
			pendOp       = opInc;
			pendData     = '0;
			clrPend      = '0;
			expRespValid = 1'b0;
			expCount     = '0;
			expWrap      = 1'b0;
		end else begin
			// read sees the state from before this edge
			expRespValid = rdValid;
			newClr       = '0;
			if (rdValid) begin
				expCount        = modelCount[rdChan];
				expWrap         = modelWrap[rdChan];
				newClr[rdChan]  = 1'b1;
			end
			for (int ch = 0; ch < numChannels; ch++) begin
				hit = 1'b0;
				if (pendValid && (pendChan == chanT'(ch))) begin
					case (pendOp)
						opInc: begin
							hit            = (modelCount[ch] == 16'hFFFF);
							modelCount[ch] = modelCount[ch] + countT'(1);
						end
						opDec: begin
							hit            = (modelCount[ch] == 16'h0000);
							modelCount[ch] = modelCount[ch] - countT'(1);
						end
						opLoad:  modelCount[ch] = pendData;
						default: modelCount[ch] = '0;  // clear
					endcase
				end
				if (pendValid && (pendChan == chanT'(ch)) && (pendOp == opClear)) begin
					modelWrap[ch] = 1'b0;
				end else if (hit) begin
					modelWrap[ch] = 1'b1;  // new wrap beats a read clear
				end else if (clrPend[ch]) begin
					modelWrap[ch] = 1'b0;
				end
			end
			clrPend   = newClr;
			pendValid = cmdValid;  // next edge's landing command
			pendChan  = cmdChan;
			pendOp    = cmdOp;
			pendData  = cmdData;
		end
	end

	// checks sample the outputs half a cycle after they change
	respMissing: assert property (@(negedge clk) disable iff (!arstN)
		expRespValid |-> rdRespValid)
	else begin
		$display("read issued but no rdRespValid in the following cycle");
		checkFails++;
	end

	respExtra: assert property (@(negedge clk) disable iff (!arstN)
		!expRespValid |-> !rdRespValid)
	else begin
		$display("rdRespValid high without a read in the cycle before");
		checkFails++;
	end

	countMatch: assert property (@(negedge clk) disable iff (!arstN)
		(expRespValid && rdRespValid) |-> (rdCount == expCount))
	else begin
		$display("ERROR rdCount expected %h actual %h", expCount, rdCount);
		checkFails++;
	end

	wrapMatch: assert property (@(negedge clk) disable iff (!arstN)
		(expRespValid && rdRespValid) |-> (rdWrap == expWrap))
	else begin
		$display("ERROR rdWrap expected %h actual %h", expWrap, rdWrap);
		checkFails++;
	end

	always @(negedge clk) begin
		if (rdRespValid) begin
			respSeen++;  // one per answered read
		end
	end

	// hang guard
	initial begin
		while (cycleCount < cycleLimit) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("run stopped after %0d cycles without finishing", cycleCount);
		$display("Regression failed");
		$finish;
	end

	// drives one cycle of inputs on the falling edge
	task automatic driveCycle(input logic doCmd, input chanT ch, input opT op,
			input countT data, input logic doRd, input chanT rch);
		@(negedge clk);
		cmdValid = doCmd;
		cmdChan  = ch;
		cmdOp    = op;
		cmdData  = data;
		rdValid  = doRd;
		rdChan   = rch;
		if (doRd) begin
			readsIssued++;
		end
	endtask

	task automatic sendCmd(input chanT ch, input opT op, input countT data);
		driveCycle(1'b1, ch, op, data, 1'b0, '0);
	endtask

	task automatic sendRead(input chanT ch);
		driveCycle(1'b0, '0, opInc, '0, 1'b1, ch);
	endtask

	task automatic idle(input int n);
		repeat (n) driveCycle(1'b0, '0, opInc, '0, 1'b0, '0);
	endtask

	task automatic waitResponses();
		int waited;
		waited = 0;
		while ((respSeen != readsIssued) && (waited < respTimeout)) begin
			@(posedge clk);
			waited++;
		end
		if (respSeen != readsIssued) begin
			$display("read responses missing: %0d issued, %0d answered", readsIssued, respSeen);
			checkFails++;
		end
	endtask

	task automatic finishTest(input string name);
		idle(1);
		waitResponses();
		if (checkFails == startFails) begin
			testsPassed++;
			$display("test %s: pass", name);
		end else begin
			testsFailed++;
			$display("test %s: fail, %0d errors", name, checkFails - startFails);
		end
		startFails = checkFails;
	endtask

	task automatic checkResetState();
		idle(2);  // no response expected while idle
		for (int ch = 0; ch < numChannels; ch++) begin
			sendRead(chanT'(ch));
		end
		finishTest("reset");
	endtask

	task automatic runRandomSteps();
		chanT ch;
		opT   op;
		logic doRd;
		// spread the start points over the whole range
		for (int i = 0; i < numChannels; i++) begin
			sendCmd(chanT'(i), opLoad, countT'($urandom()));
		end
		for (int i = 0; i < 400; i++) begin
			ch   = chanT'($urandom_range(0, numChannels - 1));
			op   = ($urandom_range(0, 1) == 0) ? opInc : opDec;
			doRd = ($urandom_range(0, 3) == 0);
			driveCycle(1'b1, ch, op, '0, doRd, chanT'($urandom_range(0, numChannels - 1)));
		end
		idle(2);
		for (int ch2 = 0; ch2 < numChannels; ch2++) begin
			sendRead(chanT'(ch2));
		end
		finishTest("random inc/dec");
	endtask

	task automatic checkUpWrap();
		sendCmd(3'd2, opLoad, 16'hFFFF);
		sendCmd(3'd2, opInc, '0);
		idle(2);
		sendRead(3'd2);  // expect count 0 with the flag set
		idle(1);         // clear lands
		sendRead(3'd2);  // flag now clear
		finishTest("upward wrap");
	endtask

	task automatic checkDownWrap();
		sendCmd(3'd5, opClear, '0);
		sendCmd(3'd5, opDec, '0);
		idle(2);
		for (int ch = 0; ch < numChannels; ch++) begin
			sendRead(chanT'(ch));  // only channel 5 moved
		end
		finishTest("downward wrap");
	endtask

	task automatic checkClear();
		sendCmd(3'd6, opLoad, 16'hFFFF);
		sendCmd(3'd6, opInc, '0);   // wrap set
		sendCmd(3'd6, opInc, '0);   // count 1 with the flag still set
		idle(1);
		sendCmd(3'd6, opClear, '0);
		idle(2);
		sendRead(3'd6);
		finishTest("clear");
	endtask

	task automatic checkReadTiming();
		sendCmd(3'd1, opLoad, 16'h1234);
		sendRead(3'd1);  // sampled as the load lands so the old value returns
		sendRead(3'd1);
		repeat (4) driveCycle(1'b1, 3'd1, opInc, '0, 1'b1, 3'd1);  // read every cycle
		// new wrap and read clear on the same edge
		sendCmd(3'd3, opLoad, 16'hFFFF);
		sendCmd(3'd3, opInc, '0);
		idle(1);
		driveCycle(1'b1, 3'd3, opDec, '0, 1'b1, 3'd3);
		idle(1);
		sendRead(3'd3);  // flag survives the clear
		finishTest("read timing");
	endtask

	initial begin
		cmdValid = 1'b0;
		cmdChan  = '0;
		cmdOp    = opInc;
		cmdData  = '0;
		rdValid  = 1'b0;
		rdChan   = '0;
		void'($urandom(32'h6247_1879));
		wait (arstN === 1'b1);
		checkResetState();
		runRandomSteps();
		checkUpWrap();
		checkDownWrap();
		checkClear();
		checkReadTiming();
		$display("tests passed %0d, failed %0d", testsPassed, testsFailed);
		if ((testsFailed == 0) && (checkFails == 0)) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

/* verif/clkGen.sv */
module clkGen (
	output logic clk,
	output logic arstN
);

	timeunit 1ns;
	timeprecision 100ps;

	localparam int halfPeriod  = 5;  // 10 ns period
	localparam int resetCycles = 2;

	initial begin
		clk = 1'b0;
		forever #halfPeriod clk = ~clk;
	end

	// reset held over two rising edges, released on a falling edge
	initial begin
		arstN = 1'b0;
		repeat (resetCycles) @(posedge clk);
		@(negedge clk);
		arstN = 1'b1;
	end

endmodule

/* rtl/counterBank.sv */
module counterBank
	import counterPkg::*;
(
	input  logic  clk,
	input  logic  arstN,
	// command port
	input  logic  cmdValid,
	input  chanT  cmdChan,
	input  opT    cmdOp,
	input  countT cmdData,
	// read port
	input  logic  rdValid,
	input  chanT  rdChan,
	output logic  rdRespValid,
	output countT rdCount,
	output logic  rdWrap
);

	chanMaskT                chanStrobe;  // dispatcher to channels
	opT                      dispOp;
	countT                   dispData;
	countT [numChannels-1:0] countBus;    // channels to readout
	chanMaskT                wrapFlags;
	chanMaskT                wrapClr;     // readout back to channels

	cmdDispatch u_cmdDispatch (
		.clk       (clk),
		.arstN     (arstN),
		.cmdValid  (cmdValid),
		.cmdChan   (cmdChan),
		.cmdOp     (cmdOp),
		.cmdData   (cmdData),
		.chanStrobe(chanStrobe),
		.dispOp    (dispOp),
		.dispData  (dispData)
	);

	// one counter per channel, op and data shared
	for (genvar ch = 0; ch < numChannels; ch++) begin : gChan
		channelCounter u_channelCounter (
			.clk     (clk),
			.arstN   (arstN),
			.strobe  (chanStrobe[ch]),
			.op      (dispOp),
			.loadData(dispData),
			.wrapClr (wrapClr[ch]),
			.count   (countBus[ch]),
			.wrap    (wrapFlags[ch])
		);
	end

	readoutMux u_readoutMux (
		.clk        (clk),
		.arstN      (arstN),
		.rdValid    (rdValid),
		.rdChan     (rdChan),
		.countBus   (countBus),
		.wrapFlags  (wrapFlags),
		.rdRespValid(rdRespValid),
		.rdCount    (rdCount),
		.rdWrap     (rdWrap),
		.wrapClr    (wrapClr)
	);

endmodule

/* rtl/readoutMux.sv */
module readoutMux
	import counterPkg::*;
(
	input  logic                    clk,
	input  logic                    arstN,
	input  logic                    rdValid,      // read strobe
	input  chanT                    rdChan,
	input  countT [numChannels-1:0] countBus,     // all channel counts
	input  chanMaskT                wrapFlags,    // all wrap flags
	output logic                    rdRespValid,  // one cycle after rdValid
	output countT                   rdCount,
	output logic                    rdWrap,
	output chanMaskT                wrapClr       // one-hot, same cycle as response
);

	chanMaskT rdHit;  // decoded read channel

	always_comb begin
		rdHit = '0;
		if (rdValid) begin
			rdHit[rdChan] = 1'b1;
		end
	end

	// response strobe and flag clear
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			rdRespValid <= 1'b0;
			wrapClr     <= '0;
		end else begin
			rdRespValid <= rdValid;
			wrapClr     <= rdHit;  // channel drops its flag at the next edge
		end
	end

	// response data, captured from the values held before this edge
	always_ff @(posedge clk) begin
		if (rdValid) begin
			rdCount <= countBus[rdChan];
			rdWrap  <= wrapFlags[rdChan];
		end
	end

endmodule

/* rtl/channelCounter.sv */
module channelCounter
	import counterPkg::*;
(
	input  logic  clk,
	input  logic  arstN,
	input  logic  strobe,    // one-cycle strobe for this channel
	input  opT    op,
	input  countT loadData,
	input  logic  wrapClr,   // flag consumed by a read
	output countT count,
	output logic  wrap       // sticky wrap flag
);

	countT stepped;   // count +/- 1 from the incdec
	logic  isInc;
	logic  isDec;
	logic  wrapHit;   // this update crosses the all-ones / zero boundary

	assign isInc = strobe && (op == opInc);
	assign isDec = strobe && (op == opDec);

	// wrap on FFFF + 1 or 0000 - 1
	assign wrapHit = (isInc && (&count)) || (isDec && !(|count));

	IncDec #(
		.width(countWidth),
		.speed(prefixSpeed)
	) u_incDec (
		.A(count),
		.DEC(op == opDec),  // don't care unless strobe
		.Z(stepped)
	);

	// count register
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			count <= '0;
		end else if (strobe) begin
			unique case (op)
				opInc,
				opDec:   count <= stepped;
				opLoad:  count <= loadData;
				opClear: count <= '0;
			endcase
		end
	end

	// wrap flag
	// a new wrap beats a pending read clear at the same edge
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			wrap <= 1'b0;
		end else if (strobe && (op == opClear)) begin
			wrap <= 1'b0;  // clear op resets the whole channel
		end else if (wrapHit) begin
			wrap <= 1'b1;
		end else if (wrapClr) begin
			wrap <= 1'b0;
		end
	end

endmodule

/* rtl/cmdDispatch.sv */
module cmdDispatch
	import counterPkg::*;
(
	input  logic     clk,
	input  logic     arstN,
	input  logic     cmdValid,    // one-cycle command strobe
	input  chanT     cmdChan,     // target channel
	input  opT       cmdOp,
	input  countT    cmdData,     // load value for opLoad
	output chanMaskT chanStrobe,  // registered one-hot strobe
	output opT       dispOp,      // shared by all channels
	output countT    dispData
);

	chanMaskT chanHit;  // decoded strobe before the register

	// channel decode
	always_comb begin
		chanHit = '0;
		if (cmdValid) begin
			chanHit[cmdChan] = 1'b1;
		end
	end

	// strobe register
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			chanStrobe <= '0;
		end else begin
			chanStrobe <= chanHit;  // drops back to zero after one cycle
		end
	end

	// opcode and data ride beside the strobe
	// only sampled by a channel while its strobe bit is high
	always_ff @(posedge clk) begin
		if (cmdValid) begin
			dispOp   <= cmdOp;
			dispData <= cmdData;
		end
	end

endmodule

/* rtl/IncDec.sv */
module IncDec #(
	parameter int width = 8,  // operand bits
	parameter int speed = 2   // prefix structure, see PrefixAnd
) (
	input  logic [width-1:0] A,    // operand
	input  logic             DEC,  // 1 gives A-1, 0 gives A+1
	output logic [width-1:0] Z     // result modulo 2^width
);

	logic [width-1:0] opnd;  // operand, inverted when decrementing
	logic [width-1:0] prop;  // prop[i] set when bits i..0 all propagate

	// a decrement borrows through zeros, so look for ones in ~A
	assign opnd = A ^ {width{DEC}};

	PrefixAnd #(
		.width(width),
		.speed(speed)
	) u_prefixAnd (
		.PI(opnd),
		.PO(prop)
	);

	// bit 0 always flips, higher bits flip once everything below propagates
	assign Z = A ^ {prop[width-2:0], 1'b1};

endmodule

/* rtl/PrefixAnd.sv */
module PrefixAnd #(
	parameter int width = 8,  // operand bits, 2 or more
	parameter int speed = 2   // 0 serial, 1 brent-kung, 2 sklansky
) (
	input  logic [width-1:0] PI,  // propagate in
	output logic [width-1:0] PO   // PO[i] is and of PI[i:0]
);

	localparam int depth = $clog2(width);  // levels of a full binary tree

	if (speed == 0) begin : gSerial
		// smallest cell count, depth grows with width
		logic [width-1:0] chain;

		assign chain[0] = PI[0];
		for (genvar i = 1; i < width; i++) begin : gBit
			assign chain[i] = chain[i-1] & PI[i];  // ripple one bit up
		end
		assign PO = chain;

	end else if (speed == 1) begin : gBrentKung
		// up-sweep over depth levels, then down-sweep over depth-1 levels
		logic [width-1:0] pt [0:2*depth-1];

		assign pt[0] = PI;

		// up-sweep builds group terms at the top bit of each aligned block
		for (genvar s = 1; s <= depth; s++) begin : gUp
			for (genvar i = 0; i < width; i++) begin : gBit
				if ((i + 1) % (2**s) == 0) begin : gDot
					assign pt[s][i] = pt[s-1][i] & pt[s-1][i - 2**(s-1)];
				end else begin : gPass
					assign pt[s][i] = pt[s-1][i];
				end
			end
		end

		// down-sweep fills the bits between the completed block tops
		for (genvar s = depth + 1; s < 2*depth; s++) begin : gDown
			localparam int span = 2**(2*depth - s - 1);  // distance to partner bit

			for (genvar i = 0; i < width; i++) begin : gBit
				if (((i + 1) % (2*span) == span) && (i >= 2*span)) begin : gDot
					assign pt[s][i] = pt[s-1][i] & pt[s-1][i - span];  // partner already full
				end else begin : gPass
					assign pt[s][i] = pt[s-1][i];
				end
			end
		end

		assign PO = pt[2*depth-1];

	end else begin : gSklansky
		// minimum depth, fanout doubles each level
		logic [width-1:0] pt [0:depth];

		assign pt[0] = PI;
		for (genvar s = 1; s <= depth; s++) begin : gLevel
			for (genvar i = 0; i < width; i++) begin : gBit
				// upper half of each block of 2^s takes the top of the lower half
				if (((i >> (s-1)) & 1) == 1) begin : gDot
					assign pt[s][i] = pt[s-1][i] & pt[s-1][((i >> (s-1)) << (s-1)) - 1];
				end else begin : gPass
					assign pt[s][i] = pt[s-1][i];
				end
			end
		end

		assign PO = pt[depth];
	end

endmodule

/* rtl/counterPkg.sv */
package counterPkg;

	localparam int countWidth  = 16;  // bits per event count
	localparam int numChannels = 8;   // counters in the bank
	localparam int chanWidth   = 3;   // enough to address numChannels
	localparam int prefixSpeed = 2;   // sklansky tree inside each incdec

	// count value or load value
	typedef logic [countWidth-1:0] countT;

	// channel number on the command and read ports
	typedef logic [chanWidth-1:0] chanT;

	// one bit per channel
	// used for one-hot strobes and for the wrap flags
	typedef logic [numChannels-1:0] chanMaskT;

	// command opcodes
	typedef enum logic [1:0] {
		opInc   = 2'd0,  // count + 1, wraps
		opDec   = 2'd1,  // count - 1, wraps
		opLoad  = 2'd2,  // count takes the load value
		opClear = 2'd3   // count and wrap flag to zero
	} opT;

endpackage
